//--- logic/dump2ddr_macros.svh
/* Shared constants of the BRAM to DDR dump master:
   bus widths, burst geometry, write ID pool and fixed AXI attributes */

`ifndef DUMP2DDR_MACROS_SVH
`define DUMP2DDR_MACROS_SVH

// ----------------------------------------------------------------------------
// Widths
// ----------------------------------------------------------------------------
`define DUMP_DW             64          // AXI and BRAM data width
`define DUMP_AW             32          // DDR byte address width
`define DUMP_IW             6           // AXI ID width
`define DUMP_BUF_AW         9           // BRAM word address, top bit picks half

// ----------------------------------------------------------------------------
// Transfer geometry
// ----------------------------------------------------------------------------
`define DUMP_BEATS          16          // Beats per burst
`define DUMP_BURST_BYTES    128         // 16 beats of 8 bytes
`define DUMP_BLOCK_BYTES    2048        // One half-buffer, 16 bursts

// Outstanding write IDs
`define DUMP_IDS            8
`define DUMP_ID_EXPIRY      31          // Countdown start of an ID in use
`define DUMP_CNT_W          6

// Fixed AW attributes, tied off in the interconnect wrapper
`define DUMP_AXI_SIZE       3'b011      // 8 bytes per beat
`define DUMP_AXI_LEN        4'b1111     // 16 beats
`define DUMP_AXI_BURST      2'b01       // INCR
`define DUMP_AXI_CACHE      4'b0001     // Bufferable only

`endif

//--- logic/dump2ddr_pkg.sv
/* Packed struct types shared by the dump master units and the testbench */

`include "dump2ddr_macros.svh"

package dump2ddr_pkg;

    // ------------------------------------------------------------------------
    // Block selection, index {ch, half} matches buf_ready_i bit order
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic ch;                           // 0 = channel A
        logic half;                         // 0 = low half
    } blk_sel_t;

    // One DDR ring buffer
    typedef struct packed {
        logic [`DUMP_AW-1:0] base_addr;     // First byte of ring
        logic [`DUMP_AW-1:0] end_addr;      // Last byte + 1
    } ring_cfg_t;

    typedef struct packed {
        logic [1:0] reload;                 // Level, pointer back to base; [0] = A
        logic [1:0] enable;                 // Dump enable per channel; [0] = A
    } dump_ctrl_t;

    // ------------------------------------------------------------------------
    // AXI write channels
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic [`DUMP_AW-1:0] addr;
        logic [`DUMP_IW-1:0] id;
        logic                valid;
    } aw_req_t;

    typedef struct packed {
        logic [`DUMP_DW-1:0] data;
        logic [`DUMP_IW-1:0] id;
        logic                last;
        logic                valid;
    } w_beat_t;

    typedef struct packed {
        logic [`DUMP_IW-1:0] id;
        logic                valid;         // Always accepted
    } b_resp_t;

endpackage

//--- logic/dump_ready_tracker.sv
/* Half-buffer ready latches and choice of the next block to send */

module dump_ready_tracker import dump2ddr_pkg::*; (
    input  logic       axi_clk_i,
    input  logic       axi_rstn_i,
    input  logic [3:0] buf_ready_i,     // Pulses Al, Ah, Bl, Bh
    input  dump_ctrl_t dump_ctrl_i,
    input  logic       blk_done_i,      // Block finishes this cycle
    input  blk_sel_t   done_blk_i,
    output logic       pending_o,
    output blk_sel_t   next_blk_o
);

    logic [3:0] rdy_q;                  // Ready latches Al, Ah, Bl, Bh
    logic [3:0] done_vec;               // One-hot of finishing block
    logic [3:0] avail;

    assign done_vec  = blk_done_i ? (4'b0001 << done_blk_i) : 4'b0000;
    assign avail     = rdy_q & ~done_vec;   // Finishing block not picked again
    assign pending_o = |avail;

    // Lowest index wins: A before B, low half before high
    always_comb begin
        next_blk_o = '0;
        for (int i = 3; i >= 0; i--) begin
            if (avail[i]) next_blk_o = blk_sel_t'(2'(i));
        end
    end

    // ------------------------------------------------------------------------
    // Latches, set to channel enable, cleared by block done
    // ------------------------------------------------------------------------
    always_ff @(posedge axi_clk_i) begin
        if (!axi_rstn_i) begin
            rdy_q <= 4'b0000;
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (buf_ready_i[i]) begin
                    rdy_q[i] <= dump_ctrl_i.enable[i / 2];  // Disabled ch drops pulse
                end else if (done_vec[i]) begin
                    rdy_q[i] <= 1'b0;
                end
            end
        end
    end

endmodule

//--- logic/dump_burst_engine.sv
/* Block and burst sequencing, BRAM read addressing and channel select,
   AW request and W beat generation */

`include "dump2ddr_macros.svh"

module dump_burst_engine import dump2ddr_pkg::*; (
    input  logic                   axi_clk_i,
    input  logic                   axi_rstn_i,
    input  logic                   pending_i,
    input  blk_sel_t               next_blk_i,
    output logic                   blk_done_o,
    output blk_sel_t               done_blk_o,
    output logic                   blk_start_o,
    output blk_sel_t               start_blk_o,
    input  logic [`DUMP_AW-1:0]    blk_addr_i,     // Ring address of started block
    input  logic                   id_free_i,
    input  logic [`DUMP_IW-1:0]    next_id_i,
    output logic                   burst_issue_o,
    output aw_req_t                aw_o,
    input  logic                   axi_awready_i,
    output w_beat_t                w_o,
    input  logic                   axi_wready_i,
    output logic [1:0]             buf_select_o,
    output logic [`DUMP_BUF_AW-1:0] buf_raddr_o,
    input  logic [`DUMP_DW-1:0]    buf_rdata_i
);

    localparam int BEAT_W = $clog2(`DUMP_BEATS);   // Beat index bits of rp
    localparam int HALF_B = `DUMP_BUF_AW - 1;      // Half select bit of rp

    logic                    tx_in_pr;      // Block transfer running
    logic                    burst_in_pr;   // W beats being offered
    logic                    aw_valid;
    logic [`DUMP_BUF_AW-1:0] rp;            // BRAM word of current beat
    logic [`DUMP_AW-1:0]     wp;            // DDR address of current burst
    logic [`DUMP_IW-1:0]     cur_id;
    blk_sel_t                cur_blk;

    logic                    beat_acc, burst_end, blk_end, can_issue;
    logic                    start_blk, next_burst, start_burst, rd_en, rd_ch;
    logic [`DUMP_BUF_AW-1:0] blk_base;

    // ------------------------------------------------------------------------
    // Scheduling
    // ------------------------------------------------------------------------
    assign beat_acc  = burst_in_pr & axi_wready_i;
    assign burst_end = beat_acc & (&rp[BEAT_W-1:0]);
    assign blk_end   = burst_end & (&rp[HALF_B-1:BEAT_W]);
    assign can_issue = id_free_i & (!aw_valid | axi_awready_i);  // Previous AW gone

    assign start_blk   = (!tx_in_pr | blk_end) & pending_i & can_issue;
    assign next_burst  = tx_in_pr & can_issue & (!burst_in_pr | (burst_end & !blk_end));
    assign start_burst = start_blk | next_burst;
    assign blk_base    = {next_blk_i.half, {HALF_B{1'b0}}};

    assign blk_start_o   = start_blk;
    assign start_blk_o   = next_blk_i;
    assign blk_done_o    = blk_end;
    assign done_blk_o    = cur_blk;
    assign burst_issue_o = start_burst;

    always_ff @(posedge axi_clk_i) begin
        if (!axi_rstn_i) begin
            tx_in_pr    <= 1'b0;
            burst_in_pr <= 1'b0;
            aw_valid    <= 1'b0;
            rp          <= '0;
            cur_blk     <= '0;
            cur_id      <= '0;
        end else begin
            if (start_blk) tx_in_pr <= 1'b1;
            else if (blk_end) tx_in_pr <= 1'b0;

            if (start_burst) burst_in_pr <= 1'b1;
            else if (burst_end) burst_in_pr <= 1'b0;    // Held for ID or AW

            if (start_burst) aw_valid <= 1'b1;
            else if (axi_awready_i) aw_valid <= 1'b0;

            if (start_blk) begin
                rp      <= blk_base;
                cur_blk <= next_blk_i;
            end else if (beat_acc) begin
                rp <= rp + 1'b1;
            end

            if (start_burst) cur_id <= next_id_i;
        end
    end

    // DDR burst address, one step per burst
    always_ff @(posedge axi_clk_i) begin
        if (!axi_rstn_i) begin
            wp <= '0;
        end else if (start_blk) begin
            wp <= blk_addr_i;
        end else if (start_burst) begin
            wp <= wp + `DUMP_AW'(`DUMP_BURST_BYTES);
        end
    end

    // ------------------------------------------------------------------------
    // BRAM read address leads the beat by one cycle
    // ------------------------------------------------------------------------
    assign rd_en = start_burst | (burst_in_pr & !burst_end);
    assign rd_ch = start_blk ? next_blk_i.ch : cur_blk.ch;

    assign buf_select_o = rd_en ? (2'b01 << rd_ch) : 2'b00;
    assign buf_raddr_o  = start_blk ? blk_base :
                          beat_acc  ? rp + 1'b1 : rp;   // Stall rereads same word

    // AXI outputs
    assign aw_o = '{addr: wp, id: cur_id, valid: aw_valid};
    assign w_o  = '{data: buf_rdata_i, id: cur_id,
                    last: burst_in_pr & (&rp[BEAT_W-1:0]), valid: burst_in_pr};

endmodule

//--- logic/ddr_ring_pointer.sv
/* Channel A and B DDR ring write pointers, block step with wrap and reload */

`include "dump2ddr_macros.svh"

module ddr_ring_pointer import dump2ddr_pkg::*; (
    input  logic                axi_clk_i,
    input  logic                axi_rstn_i,
    input  ring_cfg_t           ring_cfg_a_i,
    input  ring_cfg_t           ring_cfg_b_i,
    input  dump_ctrl_t          dump_ctrl_i,
    input  logic                blk_start_i,
    input  blk_sel_t            start_blk_i,
    output logic [`DUMP_AW-1:0] blk_addr_o,     // Same cycle as blk_start_i
    output logic [`DUMP_AW-1:0] ddr_a_curr_o,
    output logic [`DUMP_AW-1:0] ddr_b_curr_o
);

    ring_cfg_t           cfg       [2];         // Index 0 = A
    logic [`DUMP_AW-1:0] curr_q    [2];
    logic [`DUMP_AW-1:0] next_addr [2];

    assign cfg[0] = ring_cfg_a_i;
    assign cfg[1] = ring_cfg_b_i;

    always_comb begin
        for (int ch = 0; ch < 2; ch++) begin
            next_addr[ch] = curr_q[ch] + `DUMP_AW'(`DUMP_BLOCK_BYTES);
        end
    end

    assign blk_addr_o   = curr_q[start_blk_i.ch];
    assign ddr_a_curr_o = curr_q[0];
    assign ddr_b_curr_o = curr_q[1];

    // ------------------------------------------------------------------------
    // Pointer update, block start beats reload
    // ------------------------------------------------------------------------
    always_ff @(posedge axi_clk_i) begin
        if (!axi_rstn_i) begin
            curr_q[0] <= '0;
            curr_q[1] <= '0;
        end else begin
            for (int ch = 0; ch < 2; ch++) begin
                if (blk_start_i && (start_blk_i.ch == 1'(ch))) begin
                    if (next_addr[ch] >= cfg[ch].end_addr) begin
                        curr_q[ch] <= cfg[ch].base_addr;   // Wrap
                    end else begin
                        curr_q[ch] <= next_addr[ch];
                    end
                end else if (dump_ctrl_i.reload[ch]) begin
                    curr_q[ch] <= cfg[ch].base_addr;
                end
            end
        end
    end

endmodule

//--- logic/axi_id_tracker.sv
/* Write ID expiry counters and lowest idle ID choice */

`include "dump2ddr_macros.svh"

module axi_id_tracker import dump2ddr_pkg::*; (
    input  logic                axi_clk_i,
    input  logic                axi_rstn_i,
    input  logic                burst_issue_i,  // Takes next_id_o
    input  w_beat_t             w_i,            // Beats keep their ID alive
    input  b_resp_t             b_i,
    output logic                id_free_o,
    output logic [`DUMP_IW-1:0] next_id_o
);

    localparam int IDX_W = $clog2(`DUMP_IDS);
    localparam int ID_W  = `DUMP_IW;
    localparam int CNT_W = `DUMP_CNT_W;

    logic [CNT_W-1:0]    id_cnt [`DUMP_IDS];   // 0 = idle
    logic [`DUMP_IDS-1:0] id_idle;
    logic [ID_W-1:0]     low_id;

    always_comb begin
        for (int i = 0; i < `DUMP_IDS; i++) begin
            id_idle[i] = (id_cnt[i] == '0);
        end
    end

    // Lowest idle ID, keeps old choice when all busy
    always_comb begin
        low_id = next_id_o;
        for (int i = `DUMP_IDS - 1; i >= 0; i--) begin
            if (id_idle[i]) low_id = ID_W'(i);
        end
    end

    assign id_free_o = id_idle[next_id_o[IDX_W-1:0]];   // Stale pick only stalls

    // ------------------------------------------------------------------------
    // Expiry counters
    // ------------------------------------------------------------------------
    always_ff @(posedge axi_clk_i) begin
        if (!axi_rstn_i) begin
            next_id_o <= '0;
            for (int i = 0; i < `DUMP_IDS; i++) begin
                id_cnt[i] <= '0;
            end
        end else begin
            next_id_o <= low_id;
            for (int i = 0; i < `DUMP_IDS; i++) begin
                if (burst_issue_i && (next_id_o == ID_W'(i))) begin
                    id_cnt[i] <= CNT_W'(`DUMP_ID_EXPIRY);
                end else if (b_i.valid && (b_i.id == ID_W'(i))) begin
                    id_cnt[i] <= '0;                    // Response back
                end else if (!id_idle[i]) begin
                    if (w_i.valid && (w_i.id == ID_W'(i))) begin
                        id_cnt[i] <= CNT_W'(`DUMP_ID_EXPIRY);
                    end else begin
                        id_cnt[i] <= id_cnt[i] - 1'b1;  // Expires if B lost
                    end
                end
            end
        end
    end

endmodule

//--- logic/dump2ddr_top.sv
/* Dump master top level: ready tracker, burst engine,
   ring pointers and write ID tracker */

`include "dump2ddr_macros.svh"

module dump2ddr_top import dump2ddr_pkg::*; (
    input  logic                    axi_clk_i,
    input  logic                    axi_rstn_i,
    // AXI write master
    output aw_req_t                 aw_o,
    input  logic                    axi_awready_i,
    output w_beat_t                 w_o,
    input  logic                    axi_wready_i,
    input  b_resp_t                 b_i,
    // BRAM buffers
    output logic [1:0]              buf_select_o,   // [0] = A
    output logic [`DUMP_BUF_AW-1:0] buf_raddr_o,
    input  logic [3:0]              buf_ready_i,
    input  logic [`DUMP_DW-1:0]     buf_rdata_i,
    // Ring setup and state
    input  ring_cfg_t               ring_cfg_a_i,
    input  ring_cfg_t               ring_cfg_b_i,
    input  dump_ctrl_t              dump_ctrl_i,
    output logic [`DUMP_AW-1:0]     ddr_a_curr_o,
    output logic [`DUMP_AW-1:0]     ddr_b_curr_o
);

    logic                pending, blk_done, blk_start, id_free, burst_issue;
    blk_sel_t            next_blk, done_blk, start_blk;
    logic [`DUMP_AW-1:0] blk_addr;
    logic [`DUMP_IW-1:0] next_id;

    dump_ready_tracker u_ready (
        .axi_clk_i, .axi_rstn_i, .buf_ready_i, .dump_ctrl_i,
        .blk_done_i (blk_done),
        .done_blk_i (done_blk),
        .pending_o  (pending),
        .next_blk_o (next_blk)
    );

    dump_burst_engine u_engine (
        .axi_clk_i, .axi_rstn_i,
        .pending_i     (pending),
        .next_blk_i    (next_blk),
        .blk_done_o    (blk_done),
        .done_blk_o    (done_blk),
        .blk_start_o   (blk_start),
        .start_blk_o   (start_blk),
        .blk_addr_i    (blk_addr),
        .id_free_i     (id_free),
        .next_id_i     (next_id),
        .burst_issue_o (burst_issue),
        .aw_o, .axi_awready_i, .w_o, .axi_wready_i,
        .buf_select_o, .buf_raddr_o, .buf_rdata_i
    );

    ddr_ring_pointer u_ring (
        .axi_clk_i, .axi_rstn_i, .ring_cfg_a_i, .ring_cfg_b_i, .dump_ctrl_i,
        .blk_start_i (blk_start),
        .start_blk_i (start_blk),
        .blk_addr_o  (blk_addr),
        .ddr_a_curr_o, .ddr_b_curr_o
    );

    axi_id_tracker u_ids (
        .axi_clk_i, .axi_rstn_i,
        .burst_issue_i (burst_issue),
        .w_i           (w_o),           // Active ID refresh
        .b_i,
        .id_free_o     (id_free),
        .next_id_o     (next_id)
    );

endmodule

//--- tb/dump2ddr_assert.sv
/* AW hold, W hold and BRAM select assertions, bound to the top level */

module dump2ddr_assert import dump2ddr_pkg::*; (
    input logic       axi_clk_i,
    input logic       axi_rstn_i,
    input aw_req_t    aw_o,
    input logic       axi_awready_i,
    input w_beat_t    w_o,
    input logic       axi_wready_i,
    input logic [1:0] buf_select_o
);

    timeunit 1ns;
    timeprecision 100ps;

    int fail_cnt = 0;               // Failed assertions so far

    // Address and ID frozen while the slave stalls AW
    property aw_hold_p;
        @(posedge axi_clk_i) disable iff (!axi_rstn_i)
        (aw_o.valid && !axi_awready_i) |=>
            (aw_o.valid && $stable(aw_o.addr) && $stable(aw_o.id));
    endproperty

    // Stalled beat keeps its data, ID and last
    property w_hold_p;
        @(posedge axi_clk_i) disable iff (!axi_rstn_i)
        (w_o.valid && !axi_wready_i) |=>
            (w_o.valid && $stable(w_o.data) && $stable(w_o.id) && $stable(w_o.last));
    endproperty

    // Same single BRAM selected up to the last beat of a burst
    property sel_steady_p;
        @(posedge axi_clk_i) disable iff (!axi_rstn_i)
        (w_o.valid && !w_o.last) |-> ($onehot(buf_select_o) && $stable(buf_select_o));
    endproperty

    aw_hold_a: assert property (aw_hold_p) else begin
        fail_cnt++;
        $error("AW changed while stalled");
    end

    w_hold_a: assert property (w_hold_p) else begin
        fail_cnt++;
        $error("W beat changed while stalled");
    end

    sel_steady_a: assert property (sel_steady_p) else begin
        fail_cnt++;
        $error("BRAM select not steady within a burst");
    end

endmodule

bind dump2ddr_top dump2ddr_assert u_assert (.*);

//--- tb/dump2ddr_tb.sv
/* Testbench of the dump master with clock and reset, BRAM and AXI slave models,
   random ready pulses, block order and ring address model, compare tasks */

`include "dump2ddr_macros.svh"

module dump2ddr_tb import dump2ddr_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_BLOCKS = 16;
    localparam int LIMIT    = 40 * N_BLOCKS * 256;     // Cycle budget

    typedef struct packed {
        blk_sel_t            blk;
        logic [3:0]          idx;                   // Burst index within block
        logic [`DUMP_IW-1:0] id;
    } burst_rec_t;

    logic                    axi_clk, axi_rstn, awready, wready;
    aw_req_t                 aw;
    w_beat_t                 w;
    b_resp_t                 b;
    logic [1:0]              sel;
    logic [`DUMP_BUF_AW-1:0] raddr;
    logic [3:0]              rdy_pulse;
    logic [`DUMP_DW-1:0]     rdata;
    ring_cfg_t               cfg [2];
    dump_ctrl_t              ctrl;
    logic [`DUMP_AW-1:0]     curr_a, curr_b;

    // ------------------------------------------------------------------------
    // Models and scoreboard state
    // ------------------------------------------------------------------------
    logic [`DUMP_DW-1:0] mem [2][512];             // BRAM contents per channel
    burst_rec_t          bursts [$];
    logic [`DUMP_IW-1:0] b_ids [$];
    int                  b_due [$];
    logic [`DUMP_AW-1:0] ptr [2];                  // Expected ring pointers
    logic [`DUMP_AW-1:0] blk_addr;
    blk_sel_t            cur_blk;
    logic [3:0]          model_rdy, prev_avail, half_busy;
    logic [1:0]          prev_reload, rd_sel;
    logic [`DUMP_BUF_AW-1:0] rd_addr;
    logic [63:0]         out_ids;                  // IDs awaiting B
    logic                aw_hold;
    int                  seed = 70382;
    int                  cycle, aw_cnt, beat_k, blocks_done;

    dump2ddr_top DUT (
        .axi_clk_i (axi_clk), .axi_rstn_i (axi_rstn),
        .aw_o (aw), .axi_awready_i (awready), .w_o (w), .axi_wready_i (wready),
        .b_i (b), .buf_select_o (sel), .buf_raddr_o (raddr),
        .buf_ready_i (rdy_pulse), .buf_rdata_i (rdata),
        .ring_cfg_a_i (cfg[0]), .ring_cfg_b_i (cfg[1]), .dump_ctrl_i (ctrl),
        .ddr_a_curr_o (curr_a), .ddr_b_curr_o (curr_b)
    );

    initial begin
        axi_clk = 1'b0;
        forever #2 axi_clk = ~axi_clk;
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1, "run stopped");
    endtask

    // ------------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------------
    task automatic check_aw(input aw_req_t got, input aw_req_t exp);
        if (got.addr !== exp.addr || got.valid !== exp.valid) begin
            stop_run($sformatf("** Error aw_o addr/valid got %h/%h exp %h/%h",
                               got.addr, got.valid, exp.addr, exp.valid));
        end
    endtask

    task automatic check_beat(input w_beat_t got, input w_beat_t exp);
        if (got !== exp) begin
            stop_run($sformatf("** Error w_o data/id/last got %h/%h/%h exp %h/%h/%h",
                               got.data, got.id, got.last, exp.data, exp.id, exp.last));
        end
    endtask

    task automatic check_curr(input string name, input logic [`DUMP_AW-1:0] got,
                              input logic [`DUMP_AW-1:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("** Error %s got %h exp %h", name, got, exp));
        end
    endtask

    // ------------------------------------------------------------------------
    // Stimulus 1 ns after the rising edge
    // ------------------------------------------------------------------------
    task automatic drive_cycle();
        awready = ($random(seed) & 3) != 0;
        wready  = ($random(seed) & 3) != 0;
        if (rd_sel != 2'b00) rdata = mem[rd_sel[1]][rd_addr];  // One cycle read latency
        ctrl.enable = (cycle >= 1500 && cycle < 3000) ? 2'b01 : 2'b11;  // B off window
        ctrl.reload = (cycle < 8) ? 2'b11 : (cycle == 4000) ? 2'b01 : 2'b00;
        b = '0;
        if (b_ids.size() > 0 && cycle >= b_due[0]) begin
            b = '{id: b_ids[0], valid: 1'b1};
            out_ids[b_ids[0]] = 1'b0;
            void'(b_ids.pop_front());
            void'(b_due.pop_front());
        end
        rdy_pulse = 4'b0000;
        for (int h = 0; h < 4; h++) begin
            if (cycle > 20 && !half_busy[h] && ($random(seed) & 63) == 0) begin
                for (int a = 0; a < 256; a++) begin
                    mem[h / 2][{h[0], a[7:0]}] = {$random(seed), $random(seed)};
                end
                rdy_pulse[h] = 1'b1;
                if (ctrl.enable[h / 2]) half_busy[h] = 1'b1;    // Disabled pulse is lost
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // Monitor at the falling edge with all signals settled
    // ------------------------------------------------------------------------
    task automatic monitor_cycle();
        aw_req_t             exp_aw;
        w_beat_t             exp_w;
        burst_rec_t          rec;
        logic [3:0]          fin;
        logic                started;
        logic [`DUMP_AW-1:0] nxt;
        started = 1'b0;
        fin     = 4'b0000;
        // New AW request from a start decided last cycle
        if (aw.valid && !aw_hold) begin
            if (aw_cnt % 16 == 0) begin
                if (prev_avail == 4'b0000) stop_run("Block started with no half ready");
                for (int i = 3; i >= 0; i--) begin
                    if (prev_avail[i]) cur_blk = blk_sel_t'(2'(i));
                end
                blk_addr = ptr[cur_blk.ch];
                started  = 1'b1;
            end
            exp_aw = '{addr: blk_addr + 128 * (aw_cnt % 16), id: aw.id, valid: 1'b1};
            check_aw(aw, exp_aw);
            if (aw.id >= `DUMP_IDS || out_ids[aw.id])
                stop_run($sformatf("AW issued ID %0d which is busy or out of range", aw.id));
            out_ids[aw.id] = 1'b1;
            bursts.push_back('{blk: cur_blk, idx: 4'(aw_cnt % 16), id: aw.id});
            aw_cnt++;
        end
        aw_hold = aw.valid && !awready;
        // W beats against the oldest open burst
        if (w.valid) begin
            if (bursts.size() == 0) stop_run("W beat offered with no open burst");
            rec   = bursts[0];
            exp_w = '{data: mem[rec.blk.ch][{rec.blk.half, rec.idx, 4'(beat_k)}],
                      id: rec.id, last: (beat_k == 15), valid: 1'b1};
            check_beat(w, exp_w);
            if (wready) begin
                if (beat_k == 15) begin
                    b_ids.push_back(rec.id);
                    b_due.push_back(cycle + 2 + ($random(seed) & 32'h7fff) % 7);
                    if (rec.idx == 15) begin
                        fin[rec.blk]       = 1'b1;
                        half_busy[rec.blk] = 1'b0;
                        blocks_done++;
                    end
                    void'(bursts.pop_front());
                    beat_k = 0;
                end else begin
                    beat_k++;
                end
            end
        end
        // Ring pointers where a block start beats reload
        for (int ch = 0; ch < 2; ch++) begin
            if (started && cur_blk.ch == 1'(ch)) begin
                nxt     = ptr[ch] + 2048;
                ptr[ch] = (nxt >= cfg[ch].end_addr) ? cfg[ch].base_addr : nxt;
            end else if (prev_reload[ch]) begin
                ptr[ch] = cfg[ch].base_addr;
            end
        end
        check_curr("ddr_a_curr_o", curr_a, ptr[0]);
        check_curr("ddr_b_curr_o", curr_b, ptr[1]);
        // Latch model for next cycle
        prev_avail = model_rdy & ~fin;
        for (int i = 0; i < 4; i++) begin
            if (rdy_pulse[i]) model_rdy[i] = ctrl.enable[i / 2];
            else if (fin[i]) model_rdy[i] = 1'b0;
        end
        prev_reload = ctrl.reload;
        rd_sel      = sel;
        rd_addr     = raddr;
    endtask

    initial begin
        axi_rstn  = 1'b0;
        awready   = 1'b0;
        wready    = 1'b0;
        b         = '0;
        rdy_pulse = 4'b0000;
        rdata     = '0;
        ctrl      = '0;
        cfg[0]    = '{base_addr: 32'h1000_0000, end_addr: 32'h1000_2800};  // 5 blocks
        cfg[1]    = '{base_addr: 32'h2000_0000, end_addr: 32'h2000_1840};  // Passes end
        repeat (4) @(posedge axi_clk);
        #1 axi_rstn = 1'b1;
        forever begin
            @(posedge axi_clk);
            #1 drive_cycle();
        end
    end

    initial begin
        cycle       = 0;
        aw_cnt      = 0;
        beat_k      = 0;
        blocks_done = 0;
        model_rdy   = '0;
        prev_avail  = '0;
        half_busy   = '0;
        prev_reload = '0;
        rd_sel      = '0;
        rd_addr     = '0;
        out_ids     = '0;
        aw_hold     = 1'b0;
        ptr[0]      = '0;
        ptr[1]      = '0;
        while (blocks_done < N_BLOCKS) begin
            @(negedge axi_clk);
            cycle++;
            if (cycle > LIMIT) stop_run("Timeout, blocks did not complete in time");
            if (axi_rstn) monitor_cycle();
            if (DUT.u_assert.fail_cnt != 0) stop_run("A protocol assertion failed");
        end
        $display("Test OK");
        $finish;
    end

endmodule

//--- dump2ddr.f
+incdir+logic
logic/dump2ddr_pkg.sv
logic/dump_ready_tracker.sv
logic/dump_burst_engine.sv
logic/ddr_ring_pointer.sv
logic/axi_id_tracker.sv
logic/dump2ddr_top.sv
tb/dump2ddr_assert.sv
tb/dump2ddr_tb.sv
